/* verilog/jump_pkg.sv */
package jump_pkg;

   ////////////////////////////////////////////////////////////
   // widths with a meaning
   ////////////////////////////////////////////////////////////

   // instruction word or fetch address
   typedef logic [15:0] word_t;

   // register file index, bits 11:8 of a register jump
   typedef logic [3:0] reg_idx_t;

   // position of an instruction inside the bundle
   typedef logic [1:0] slot_t;

   ////////////////////////////////////////////////////////////
   // control fsm
   ////////////////////////////////////////////////////////////

   // idle -> wait on register jump, wait -> resolve on base_rdy
   typedef enum logic [1:0] {
      JS_IDLE    = 2'd0,
      JS_WAIT    = 2'd1,
      JS_RESOLVE = 2'd2
   } jump_state_e;

   ////////////////////////////////////////////////////////////
   // encodings
   ////////////////////////////////////////////////////////////

   // bits 15:12 all ones mark a jump
   localparam logic [3:0] JUMP_OPCODE = 4'b1111;

   // squashed slot
   localparam word_t NOP_WORD = 16'h0000;

   // instructions per fetch bundle
   localparam int FETCH_WIDTH = 4;

endpackage

/* verilog/jump_decode.sv */
`timescale 1ns/1ps

module jump_decode (
   input  jump_pkg::word_t    instr0,
   input  jump_pkg::word_t    instr1,
   input  jump_pkg::word_t    instr2,
   input  jump_pkg::word_t    instr3,
   output logic               jump_found,
   output jump_pkg::slot_t    jump_slot,
   output logic               jump_is_reg,
   output jump_pkg::word_t    imm_offset,
   output jump_pkg::word_t    reg_disp,
   output jump_pkg::reg_idx_t base_idx
);

   import jump_pkg::*;

   // bundle as an array so the slot scan is a loop
   word_t slot_word [FETCH_WIDTH];
   logic  [FETCH_WIDTH-1:0] is_jump;

   // word of the first jump, slot 0 when there is none
   word_t sel_word;

   assign slot_word[0] = instr0;
   assign slot_word[1] = instr1;
   assign slot_word[2] = instr2;
   assign slot_word[3] = instr3;

   ////////////////////////////////////////////////////////////
   // per slot opcode check
   ////////////////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < FETCH_WIDTH; i++) begin
         is_jump[i] = (slot_word[i][15:12] == JUMP_OPCODE);
      end
   end

   ////////////////////////////////////////////////////////////
   // priority encode, lowest slot wins
   ////////////////////////////////////////////////////////////

   always_comb begin
      jump_slot = '0;
      sel_word  = slot_word[0];
      // scan from the top so the lowest jump is written last
      for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
         if (is_jump[i]) begin
            jump_slot = slot_t'(i);
            sel_word  = slot_word[i];
         end
      end
   end

   assign jump_found = |is_jump;

   // bit 0 set selects the register form
   assign jump_is_reg = jump_found & sel_word[0];

   ////////////////////////////////////////////////////////////
   // operand fields of the selected jump
   ////////////////////////////////////////////////////////////

   // immediate offset, 10 bits sign extended
   assign imm_offset = {{6{sel_word[11]}}, sel_word[11:2]};

   // register displacement, 6 bits sign extended
   assign reg_disp = {{10{sel_word[7]}}, sel_word[7:2]};

   // base register, overlaps the upper offset bits
   assign base_idx = sel_word[11:8];

endmodule

/* verilog/jump_control.sv */
`timescale 1ns/1ps

module jump_control (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               flush,
   input  jump_pkg::word_t    fetch_pc,
   input  logic               jump_found,
   input  jump_pkg::slot_t    jump_slot,
   input  logic               jump_is_reg,
   input  jump_pkg::word_t    imm_offset,
   input  jump_pkg::word_t    reg_disp,
   input  jump_pkg::reg_idx_t base_idx,
   input  jump_pkg::word_t    base_value,
   input  logic               base_rdy,
   output logic               redirect,
   output jump_pkg::word_t    redirect_pc,
   output logic               stall,
   output logic               squash_all,
   output jump_pkg::reg_idx_t base_reg
);

   import jump_pkg::*;

   jump_state_e state_q;
   jump_state_e state_d;

   // captured operands of a pending register jump
   reg_idx_t idx_q;
   word_t    disp_q;
   word_t    base_q;

   word_t imm_target;
   word_t reg_target;

   // register jump seen while idle
   logic reg_start;

   assign reg_start = (state_q == JS_IDLE) && jump_found && jump_is_reg;

   ////////////////////////////////////////////////////////////
   // target arithmetic
   ////////////////////////////////////////////////////////////

   // pc plus slot plus 1 plus offset
   assign imm_target = fetch_pc + {14'd0, jump_slot} + 16'd1 + imm_offset;

   assign reg_target = base_q + disp_q;

   ////////////////////////////////////////////////////////////
   // state register and next state
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= JS_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         JS_IDLE: begin
            if (reg_start) begin
               state_d = JS_WAIT;
            end
         end
         JS_WAIT: begin
            if (base_rdy) begin
               state_d = JS_RESOLVE;
            end
         end
         // single cycle
         JS_RESOLVE: state_d = JS_IDLE;
         default:    state_d = JS_IDLE;
      endcase
      // mispredict cancels whatever is pending
      if (flush) begin
         state_d = JS_IDLE;
      end
   end

   ////////////////////////////////////////////////////////////
   // operand capture
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      // index and displacement at detection
      if (reg_start) begin
         idx_q  <= base_idx;
         disp_q <= reg_disp;
      end
      // base value when the register file answers
      if ((state_q == JS_WAIT) && base_rdy) begin
         base_q <= base_value;
      end
   end

   ////////////////////////////////////////////////////////////
   // outputs
   ////////////////////////////////////////////////////////////

   always_comb begin
      redirect    = 1'b0;
      redirect_pc = imm_target;
      stall       = 1'b0;
      squash_all  = 1'b0;
      base_reg    = base_idx;
      case (state_q)
         JS_IDLE: begin
            // immediate redirects now, register form stalls
            if (jump_found) begin
               stall    = jump_is_reg;
               redirect = !jump_is_reg;
            end
         end
         JS_WAIT: begin
            stall      = 1'b1;
            squash_all = 1'b1;
            base_reg   = idx_q;
         end
         JS_RESOLVE: begin
            redirect    = 1'b1;
            redirect_pc = reg_target;
            stall       = 1'b1;
            squash_all  = 1'b1;
            base_reg    = idx_q;
         end
         default: begin
            stall = 1'b0;
         end
      endcase
   end

endmodule

/* verilog/fetch_redirect.sv */
`timescale 1ns/1ps

module fetch_redirect #(
   parameter jump_pkg::word_t RESET_PC = '0
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            flush,
   input  jump_pkg::word_t flush_pc,
   input  logic            redirect,
   input  jump_pkg::word_t redirect_pc,
   input  logic            stall,
   input  logic            squash_all,
   input  logic            jump_found,
   input  jump_pkg::slot_t jump_slot,
   input  logic            jump_is_reg,
   input  jump_pkg::word_t instr0,
   input  jump_pkg::word_t instr1,
   input  jump_pkg::word_t instr2,
   input  jump_pkg::word_t instr3,
   output jump_pkg::word_t fetch_pc,
   output jump_pkg::word_t issue0,
   output jump_pkg::word_t issue1,
   output jump_pkg::word_t issue2,
   output jump_pkg::word_t issue3
);

   import jump_pkg::*;

   word_t in_word  [FETCH_WIDTH];
   word_t out_word [FETCH_WIDTH];

   ////////////////////////////////////////////////////////////
   // fetch pc
   ////////////////////////////////////////////////////////////

   // flush, then redirect, then stall hold, else next bundle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_pc <= RESET_PC;
      end else if (flush) begin
         fetch_pc <= flush_pc;
      end else if (redirect) begin
         fetch_pc <= redirect_pc;
      end else if (!stall) begin
         fetch_pc <= fetch_pc + word_t'(FETCH_WIDTH);
      end
   end

   ////////////////////////////////////////////////////////////
   // slot squashing
   ////////////////////////////////////////////////////////////

   assign in_word[0] = instr0;
   assign in_word[1] = instr1;
   assign in_word[2] = instr2;
   assign in_word[3] = instr3;

   always_comb begin
      for (int i = 0; i < FETCH_WIDTH; i++) begin
         out_word[i] = in_word[i];
         if (squash_all) begin
            out_word[i] = NOP_WORD;
         end else if (jump_found) begin
            // later slots always go, the jump itself only if register form
            if ((i > int'(jump_slot)) || ((i == int'(jump_slot)) && jump_is_reg)) begin
               out_word[i] = NOP_WORD;
            end
         end
      end
   end

   assign issue0 = out_word[0];
   assign issue1 = out_word[1];
   assign issue2 = out_word[2];
   assign issue3 = out_word[3];

endmodule

/* verilog/jump_unit_top.sv */
`timescale 1ns/1ps

module jump_unit_top #(
   parameter jump_pkg::word_t RESET_PC = '0
) (
   input  logic               clk,
   input  logic               rst_n,
   input  jump_pkg::word_t    instr0,
   input  jump_pkg::word_t    instr1,
   input  jump_pkg::word_t    instr2,
   input  jump_pkg::word_t    instr3,
   input  logic               flush,
   input  jump_pkg::word_t    flush_pc,
   input  jump_pkg::word_t    base_value,
   input  logic               base_rdy,
   output jump_pkg::word_t    fetch_pc,
   output jump_pkg::reg_idx_t base_reg,
   output logic               stall,
   output logic               redirect,
   output jump_pkg::word_t    issue0,
   output jump_pkg::word_t    issue1,
   output jump_pkg::word_t    issue2,
   output jump_pkg::word_t    issue3
);

   import jump_pkg::*;

   ////////////////////////////////////////////////////////////
   // decode to control and redirect
   ////////////////////////////////////////////////////////////

   logic     jump_found;
   slot_t    jump_slot;
   logic     jump_is_reg;
   word_t    imm_offset;
   word_t    reg_disp;
   reg_idx_t base_idx;

   // control to redirect
   word_t redirect_pc;
   logic  squash_all;

   jump_decode u_decode (
      .instr0      (instr0),
      .instr1      (instr1),
      .instr2      (instr2),
      .instr3      (instr3),
      .jump_found  (jump_found),
      .jump_slot   (jump_slot),
      .jump_is_reg (jump_is_reg),
      .imm_offset  (imm_offset),
      .reg_disp    (reg_disp),
      .base_idx    (base_idx)
   );

   jump_control u_control (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .fetch_pc    (fetch_pc),
      .jump_found  (jump_found),
      .jump_slot   (jump_slot),
      .jump_is_reg (jump_is_reg),
      .imm_offset  (imm_offset),
      .reg_disp    (reg_disp),
      .base_idx    (base_idx),
      .base_value  (base_value),
      .base_rdy    (base_rdy),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .stall       (stall),
      .squash_all  (squash_all),
      .base_reg    (base_reg)
   );

   // pc register and issue masking
   fetch_redirect #(
      .RESET_PC (RESET_PC)
   ) u_redirect (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .flush_pc    (flush_pc),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .stall       (stall),
      .squash_all  (squash_all),
      .jump_found  (jump_found),
      .jump_slot   (jump_slot),
      .jump_is_reg (jump_is_reg),
      .instr0      (instr0),
      .instr1      (instr1),
      .instr2      (instr2),
      .instr3      (instr3),
      .fetch_pc    (fetch_pc),
      .issue0      (issue0),
      .issue1      (issue1),
      .issue2      (issue2),
      .issue3      (issue3)
   );

endmodule

/* test/jump_unit_sva.sv */
`timescale 1ns/1ps

module jump_unit_sva (
   input logic               clk,
   input logic               rst_n,
   input logic               flush,
   input logic               redirect,
   input logic               stall,
   input jump_pkg::reg_idx_t base_reg
);

   ////////////////////////////////////////////////////////////
   // register jump rules
   ////////////////////////////////////////////////////////////

   // only the resolve redirect comes with stall, one cycle of it
   a_resolve_once: assert property (@(posedge clk) disable iff (!rst_n)
      (redirect && stall) |=> !(redirect && stall))
      else $error("resolve redirect on two consecutive cycles");

   // a stalled register jump keeps stall up until its redirect
   a_stall_held: assert property (@(posedge clk) disable iff (!rst_n)
      (stall && !redirect && !flush) |=> stall)
      else $error("stall dropped before the resolve cycle");

   // index to the register file cannot move while waiting
   a_base_reg_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (stall && !redirect && !flush) |=> $stable(base_reg))
      else $error("base_reg changed during wait");

endmodule

bind jump_control jump_unit_sva u_sva (
   .clk      (clk),
   .rst_n    (rst_n),
   .flush    (flush),
   .redirect (redirect),
   .stall    (stall),
   .base_reg (base_reg)
);

/* test/tb_jump_unit.sv */
`timescale 1ns/1ps

module tb_jump_unit;

   import jump_pkg::*;

   localparam word_t START_PC   = 16'h0040;
   localparam int    ST_IDLE    = 0;
   localparam int    ST_WAIT    = 1;
   localparam int    ST_RESOLVE = 2;

   logic     clk;
   logic     rst_n;
   word_t    instr0;
   word_t    instr1;
   word_t    instr2;
   word_t    instr3;
   logic     flush;
   word_t    flush_pc;
   word_t    base_value;
   logic     base_rdy;
   word_t    fetch_pc;
   reg_idx_t base_reg;
   logic     stall;
   logic     redirect;
   word_t    issue0;
   word_t    issue1;
   word_t    issue2;
   word_t    issue3;

   // instruction memory and register file models
   word_t    imem [0:65535];
   word_t    regs [16];
   int       rf_wait;
   int       rf_delay;
   reg_idx_t rf_idx;

   // flush request for the next driven cycle
   logic  flush_req;
   word_t flush_tgt;

   // reference model state
   int       m_state;
   word_t    m_pc;
   reg_idx_t m_idx;
   word_t    m_disp;
   word_t    m_base;

   int errors;
   int tests;

   jump_unit_top #(
      .RESET_PC (START_PC)
   ) u_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .instr0     (instr0),
      .instr1     (instr1),
      .instr2     (instr2),
      .instr3     (instr3),
      .flush      (flush),
      .flush_pc   (flush_pc),
      .base_value (base_value),
      .base_rdy   (base_rdy),
      .fetch_pc   (fetch_pc),
      .base_reg   (base_reg),
      .stall      (stall),
      .redirect   (redirect),
      .issue0     (issue0),
      .issue1     (issue1),
      .issue2     (issue2),
      .issue3     (issue3)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////

   function automatic word_t sext10(input logic [9:0] v);
      return {{6{v[9]}}, v};
   endfunction

   function automatic word_t sext6(input logic [5:0] v);
      return {{10{v[5]}}, v};
   endfunction

   // background word, top bit clear so never a jump
   function automatic word_t bg_word(input int a);
      return word_t'((a ^ (a >> 3)) & 32'h7fff);
   endfunction

   function automatic word_t imm_jump(input int off);
      logic [9:0] o;
      o = off[9:0];
      return {4'hf, o, 2'b00};
   endfunction

   function automatic word_t reg_jump(input reg_idx_t idx, input int disp);
      logic [5:0] d;
      d = disp[5:0];
      return {4'hf, idx, d, 2'b01};
   endfunction

   function automatic word_t issue_at(input int k);
      case (k)
         0: return issue0;
         1: return issue1;
         2: return issue2;
         default: return issue3;
      endcase
   endfunction

   task automatic fill_mem();
      for (int a = 0; a < 65536; a++) begin
         imem[a] = bg_word(a);
      end
   endtask

   task automatic report_mismatch(input string sig, input word_t got, input word_t exp);
      $display("mismatch %s at %0t: got %h, expected %h", sig, $time, got, exp);
      errors++;
   endtask

   task automatic end_test(input string name, input int err_before);
      $display("%s: %0d errors", name, errors - err_before);
      tests++;
   endtask

   ////////////////////////////////////////////////////////////
   // one clock: drive, reference check, model update
   ////////////////////////////////////////////////////////////

   task automatic run_cycle();
      word_t    b [4];
      word_t    e_issue [4];
      word_t    tgt;
      int       js;
      logic     e_stall;
      logic     e_redir;
      reg_idx_t e_idx;
      @(negedge clk);
      for (int k = 0; k < 4; k++) begin
         b[k] = imem[fetch_pc + word_t'(k)];
      end
      instr0     = b[0];
      instr1     = b[1];
      instr2     = b[2];
      instr3     = b[3];
      flush      = flush_req;
      flush_pc   = flush_tgt;
      base_rdy   = (rf_wait == 0);
      base_value = regs[rf_idx];
      #1;
      // lowest jumping slot
      js = -1;
      for (int k = 3; k >= 0; k--) begin
         if (b[k][15:12] == 4'hf) begin
            js = k;
         end
      end
      e_stall = 1'b0;
      e_redir = 1'b0;
      e_idx   = m_idx;
      tgt     = m_pc;
      for (int k = 0; k < 4; k++) begin
         e_issue[k] = b[k];
      end
      if (m_state == ST_IDLE && js >= 0 && b[js][0]) begin
         // register form, jump slot squashed too
         e_stall = 1'b1;
         e_idx   = b[js][11:8];
         for (int k = js; k < 4; k++) begin
            e_issue[k] = 16'h0000;
         end
      end else if (m_state == ST_IDLE && js >= 0) begin
         e_redir = 1'b1;
         tgt     = m_pc + word_t'(js) + 16'd1 + sext10(b[js][11:2]);
         for (int k = js + 1; k < 4; k++) begin
            e_issue[k] = 16'h0000;
         end
      end else if (m_state != ST_IDLE) begin
         // waiting or resolving, whole bundle dropped
         e_stall = 1'b1;
         e_redir = (m_state == ST_RESOLVE);
         tgt     = m_base + m_disp;
         for (int k = 0; k < 4; k++) begin
            e_issue[k] = 16'h0000;
         end
      end
      if (fetch_pc !== m_pc) report_mismatch("fetch_pc", fetch_pc, m_pc);
      if (stall !== e_stall) report_mismatch("stall", word_t'(stall), word_t'(e_stall));
      if (redirect !== e_redir) report_mismatch("redirect", word_t'(redirect), word_t'(e_redir));
      if (e_stall && base_reg !== e_idx)
         report_mismatch("base_reg", word_t'(base_reg), word_t'(e_idx));
      for (int k = 0; k < 4; k++) begin
         if (issue_at(k) !== e_issue[k])
            report_mismatch($sformatf("issue%0d", k), issue_at(k), e_issue[k]);
      end
      // pc and state after the edge
      if (flush_req) begin
         m_pc = flush_tgt;
      end else if (e_redir) begin
         m_pc = tgt;
      end else if (!e_stall) begin
         m_pc = m_pc + 16'd4;
      end
      if (flush_req) begin
         m_state = ST_IDLE;
      end else if (m_state == ST_IDLE && e_stall) begin
         m_state = ST_WAIT;
         m_idx   = e_idx;
         m_disp  = sext6(b[js][7:2]);
      end else if (m_state == ST_WAIT && base_rdy) begin
         m_state = ST_RESOLVE;
         m_base  = base_value;
      end else if (m_state == ST_RESOLVE) begin
         m_state = ST_IDLE;
      end
      // register file answers a pending read after rf_delay cycles
      if (base_rdy || flush_req || !stall || redirect) begin
         rf_wait = -1;
      end else if (rf_wait < 0) begin
         rf_wait = rf_delay;
         rf_idx  = base_reg;
      end else if (rf_wait > 0) begin
         rf_wait--;
      end
   endtask

   task automatic do_flush(input word_t target);
      flush_req = 1'b1;
      flush_tgt = target;
      run_cycle();
      flush_req = 1'b0;
   endtask

   task automatic wait_redirect(input int max_cycles, output logic seen);
      int n;
      seen = 1'b0;
      n    = 0;
      while (!seen && n < max_cycles) begin
         run_cycle();
         seen = redirect;
         n++;
      end
      if (!seen) begin
         $display("timeout: no redirect within %0d cycles", max_cycles);
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////

   task automatic test_straight();
      int    e0;
      word_t exp;
      e0 = errors;
      fill_mem();
      do_flush(16'h0100);
      for (int i = 0; i < 8; i++) begin
         run_cycle();
         exp = 16'h0100 + word_t'(4 * i);
         if (fetch_pc !== exp) report_mismatch("fetch_pc", fetch_pc, exp);
         if (stall !== 1'b0) report_mismatch("stall", word_t'(stall), 16'h0);
         if (redirect !== 1'b0) report_mismatch("redirect", word_t'(redirect), 16'h0);
         for (int k = 0; k < 4; k++) begin
            if (issue_at(k) !== imem[exp + word_t'(k)])
               report_mismatch($sformatf("issue%0d", k), issue_at(k), imem[exp + word_t'(k)]);
         end
      end
      end_test("straight_fetch", e0);
   endtask

   task automatic test_imm();
      int    e0;
      int    off;
      word_t pc0;
      word_t tgt;
      word_t exp;
      e0 = errors;
      fill_mem();
      for (int s = 0; s < 4; s++) begin
         for (int n = 0; n < 2; n++) begin
            off = (n == 0) ? 20 + s : -9 - 3 * s;
            pc0 = 16'h0400 + word_t'(64 * s + 16 * n);
            imem[pc0 + word_t'(s)] = imm_jump(off);
            do_flush(pc0);
            run_cycle();
            if (redirect !== 1'b1) report_mismatch("redirect", word_t'(redirect), 16'h1);
            if (stall !== 1'b0) report_mismatch("stall", word_t'(stall), 16'h0);
            for (int k = 0; k < 4; k++) begin
               exp = (k > s) ? 16'h0000 : imem[pc0 + word_t'(k)];
               if (issue_at(k) !== exp)
                  report_mismatch($sformatf("issue%0d", k), issue_at(k), exp);
            end
            tgt = pc0 + word_t'(s) + 16'd1 + word_t'(off);
            run_cycle();
            if (fetch_pc !== tgt) report_mismatch("fetch_pc", fetch_pc, tgt);
            imem[pc0 + word_t'(s)] = bg_word(int'(pc0) + s);
         end
      end
      end_test("immediate_jumps", e0);
   endtask

   task automatic test_reg();
      int    e0;
      int    n;
      logic  seen;
      logic  rdy_prev;
      word_t pc0;
      e0  = errors;
      pc0 = 16'h0800;
      fill_mem();
      regs[5]  = 16'h3000;
      rf_delay = 3;
      imem[pc0 + 16'd2] = reg_jump(4'd5, -3);
      do_flush(pc0);
      // detection cycle
      run_cycle();
      if (stall !== 1'b1) report_mismatch("stall", word_t'(stall), 16'h1);
      if (redirect !== 1'b0) report_mismatch("redirect", word_t'(redirect), 16'h0);
      if (base_reg !== 4'd5) report_mismatch("base_reg", word_t'(base_reg), 16'h5);
      if (issue0 !== imem[pc0]) report_mismatch("issue0", issue0, imem[pc0]);
      if (issue1 !== imem[pc0 + 16'd1]) report_mismatch("issue1", issue1, imem[pc0 + 16'd1]);
      if (issue2 !== 16'h0000) report_mismatch("issue2", issue2, 16'h0000);
      if (issue3 !== 16'h0000) report_mismatch("issue3", issue3, 16'h0000);
      seen     = 1'b0;
      rdy_prev = 1'b0;
      n        = 0;
      while (!seen && n < 20) begin
         rdy_prev = base_rdy;
         run_cycle();
         n++;
         if (fetch_pc !== pc0) report_mismatch("fetch_pc", fetch_pc, pc0);
         if (stall !== 1'b1) report_mismatch("stall", word_t'(stall), 16'h1);
         for (int k = 0; k < 4; k++) begin
            if (issue_at(k) !== 16'h0000)
               report_mismatch($sformatf("issue%0d", k), issue_at(k), 16'h0);
         end
         seen = redirect;
      end
      if (!seen) begin
         $display("timeout: register jump never redirected");
         errors++;
      end else if (!rdy_prev) begin
         $display("redirect did not come one cycle after base_rdy");
         errors++;
      end
      run_cycle();
      // base 0x3000 plus displacement -3
      if (fetch_pc !== 16'h2ffd) report_mismatch("fetch_pc", fetch_pc, 16'h2ffd);
      if (stall !== 1'b0) report_mismatch("stall", word_t'(stall), 16'h0);
      end_test("register_jump", e0);
   endtask

   task automatic test_first();
      int    e0;
      logic  seen;
      word_t pc0;
      e0 = errors;
      fill_mem();
      // immediate in slot 1 ahead of a register jump
      pc0 = 16'h0c00;
      imem[pc0 + 16'd1] = imm_jump(8);
      imem[pc0 + 16'd2] = reg_jump(4'd3, 4);
      do_flush(pc0);
      run_cycle();
      if (redirect !== 1'b1) report_mismatch("redirect", word_t'(redirect), 16'h1);
      if (stall !== 1'b0) report_mismatch("stall", word_t'(stall), 16'h0);
      if (issue1 !== imem[pc0 + 16'd1]) report_mismatch("issue1", issue1, imem[pc0 + 16'd1]);
      if (issue2 !== 16'h0000) report_mismatch("issue2", issue2, 16'h0000);
      run_cycle();
      if (fetch_pc !== pc0 + 16'd10) report_mismatch("fetch_pc", fetch_pc, pc0 + 16'd10);
      // register jump in slot 0 ahead of an immediate
      pc0      = 16'h0d00;
      regs[7]  = 16'h5550;
      rf_delay = 0;
      imem[pc0]         = reg_jump(4'd7, 2);
      imem[pc0 + 16'd3] = imm_jump(-30);
      do_flush(pc0);
      run_cycle();
      if (stall !== 1'b1) report_mismatch("stall", word_t'(stall), 16'h1);
      if (base_reg !== 4'd7) report_mismatch("base_reg", word_t'(base_reg), 16'h7);
      if (issue0 !== 16'h0000) report_mismatch("issue0", issue0, 16'h0000);
      wait_redirect(10, seen);
      run_cycle();
      if (seen && fetch_pc !== 16'h5552) report_mismatch("fetch_pc", fetch_pc, 16'h5552);
      end_test("first_jump_wins", e0);
   endtask

   task automatic test_flush();
      int    e0;
      word_t pc0;
      e0 = errors;
      fill_mem();
      // flush while waiting on the register file
      pc0      = 16'h1000;
      rf_delay = 50;
      imem[pc0 + 16'd1] = reg_jump(4'd2, 1);
      do_flush(pc0);
      run_cycle();
      run_cycle();
      run_cycle();
      do_flush(16'h1200);
      if (stall !== 1'b1) report_mismatch("stall", word_t'(stall), 16'h1);
      for (int i = 0; i < 8; i++) begin
         run_cycle();
         if (stall !== 1'b0) report_mismatch("stall", word_t'(stall), 16'h0);
         if (redirect !== 1'b0) report_mismatch("redirect", word_t'(redirect), 16'h0);
      end
      // eighth bundle after the flush target
      if (fetch_pc !== 16'h121c) report_mismatch("fetch_pc", fetch_pc, 16'h121c);
      // flush beats an immediate redirect
      pc0 = 16'h1400;
      imem[pc0 + 16'd2] = imm_jump(40);
      do_flush(pc0);
      do_flush(16'h1600);
      if (redirect !== 1'b1) report_mismatch("redirect", word_t'(redirect), 16'h1);
      run_cycle();
      if (fetch_pc !== 16'h1600) report_mismatch("fetch_pc", fetch_pc, 16'h1600);
      rf_delay = 0;
      end_test("flush", e0);
   endtask

   task automatic test_random();
      int e0;
      e0 = errors;
      // about one word in sixteen is a jump
      for (int a = 0; a < 65536; a++) begin
         imem[a] = word_t'($urandom);
      end
      for (int r = 0; r < 16; r++) begin
         regs[r] = word_t'($urandom);
      end
      for (int i = 0; i < 400; i++) begin
         rf_delay  = int'($urandom % 5);
         flush_req = (($urandom % 40) == 0);
         flush_tgt = word_t'($urandom);
         run_cycle();
         flush_req = 1'b0;
      end
      end_test("random_run", e0);
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(59));
      errors     = 0;
      tests      = 0;
      rst_n      = 1'b0;
      instr0     = '0;
      instr1     = '0;
      instr2     = '0;
      instr3     = '0;
      flush      = 1'b0;
      flush_pc   = '0;
      base_value = '0;
      base_rdy   = 1'b0;
      flush_req  = 1'b0;
      flush_tgt  = '0;
      rf_wait    = -1;
      rf_delay   = 0;
      rf_idx     = '0;
      m_state    = ST_IDLE;
      m_idx      = '0;
      m_disp     = '0;
      m_base     = '0;
      for (int r = 0; r < 16; r++) begin
         regs[r] = '0;
      end
      fill_mem();
      repeat (2) @(negedge clk);
      if (fetch_pc !== START_PC) report_mismatch("fetch_pc", fetch_pc, START_PC);
      if (stall !== 1'b0) report_mismatch("stall", word_t'(stall), 16'h0);
      rst_n = 1'b1;
      // all zero bundle runs at the first edge out of reset
      m_pc = START_PC + 16'd4;
      test_straight();
      test_imm();
      test_reg();
      test_first();
      test_flush();
      test_random();
      $display("tests run: %0d, errors: %0d", tests, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* list.f */
verilog/jump_pkg.sv
verilog/jump_decode.sv
verilog/jump_control.sv
verilog/fetch_redirect.sv
verilog/jump_unit_top.sv
test/jump_unit_sva.sv
test/tb_jump_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_jump_unit
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' list.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) list.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f list.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
